// ==== Makefile ====
TOP = tb_axi_read_xlat

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== list.f ====
source/xlat_pkg.sv
source/sync_fifo.sv
source/pte_match.sv
source/read_xlat.sv
source/page_walker.sv
source/phys_read_arb.sv
source/axi_read_xlat.sv
tb/phys_mem_model.sv
tb/tb_axi_read_xlat.sv

// ==== source/axi_read_xlat.sv ====
// AXI read address translation top
`timescale 1ns/1ps

module axi_read_xlat #(
	parameter logic [xlat_pkg::PTE_APP_HI-xlat_pkg::PTE_APP_LO:0] APP_ID = '0,
	parameter int LOG_DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        rst,

	input  logic [xlat_pkg::ID_W-1:0]   ar_id,
	input  logic [xlat_pkg::ADDR_W-1:0] ar_addr,
	input  logic [xlat_pkg::LEN_W-1:0]  ar_len,
	input  logic [xlat_pkg::SIZE_W-1:0] ar_size,
	input  logic                        ar_valid,
	output logic                        ar_ready,
	output logic [xlat_pkg::ID_W-1:0]   r_id,
	output logic [xlat_pkg::DATA_W-1:0] r_data,
	output logic [xlat_pkg::RESP_W-1:0] r_resp,
	output logic                        r_last,
	output logic                        r_valid,
	input  logic                        r_ready,

	output logic [xlat_pkg::ID_W-1:0]   m_ar_id,
	output logic [xlat_pkg::ADDR_W-1:0] m_ar_addr,
	output logic [xlat_pkg::LEN_W-1:0]  m_ar_len,
	output logic [xlat_pkg::SIZE_W-1:0] m_ar_size,
	output logic                        m_ar_valid,
	input  logic                        m_ar_ready,
	input  logic [xlat_pkg::ID_W-1:0]   m_r_id,
	input  logic [xlat_pkg::DATA_W-1:0] m_r_data,
	input  logic [xlat_pkg::RESP_W-1:0] m_r_resp,
	input  logic                        m_r_last,
	input  logic                        m_r_valid,
	output logic                        m_r_ready
);
	logic [xlat_pkg::PAGE_W-1:0] xreq_page, xresp_page;
	logic xreq_valid, xreq_ready, xresp_ok, xresp_valid, xresp_ready;

	logic [xlat_pkg::ADDR_W-1:0] w_ar_addr, p_ar_addr;
	logic [xlat_pkg::LEN_W-1:0]  p_ar_len;
	logic [xlat_pkg::SIZE_W-1:0] p_ar_size;
	logic [xlat_pkg::DATA_W-1:0] w_r_data, p_r_data;
	logic [xlat_pkg::RESP_W-1:0] p_r_resp;
	logic w_ar_valid, w_ar_ready, w_r_valid, w_r_ready;
	logic p_ar_valid, p_ar_ready, p_r_last, p_r_valid, p_r_ready;

	read_xlat #(.LOG_DEPTH(LOG_DEPTH)) u_read (
		.clk(clk), .rst(rst),
		.ar_id(ar_id), .ar_addr(ar_addr), .ar_len(ar_len), .ar_size(ar_size),
		.ar_valid(ar_valid), .ar_ready(ar_ready),
		.r_id(r_id), .r_data(r_data), .r_resp(r_resp), .r_last(r_last),
		.r_valid(r_valid), .r_ready(r_ready),
		.xreq_page(xreq_page), .xreq_valid(xreq_valid), .xreq_ready(xreq_ready),
		.xresp_page(xresp_page), .xresp_ok(xresp_ok),
		.xresp_valid(xresp_valid), .xresp_ready(xresp_ready),
		.p_ar_addr(p_ar_addr), .p_ar_len(p_ar_len), .p_ar_size(p_ar_size),
		.p_ar_valid(p_ar_valid), .p_ar_ready(p_ar_ready),
		.p_r_data(p_r_data), .p_r_resp(p_r_resp), .p_r_last(p_r_last),
		.p_r_valid(p_r_valid), .p_r_ready(p_r_ready)
	);

	page_walker #(.APP_ID(APP_ID), .LOG_DEPTH(LOG_DEPTH)) u_walker (
		.clk(clk), .rst(rst),
		.xreq_page(xreq_page), .xreq_valid(xreq_valid), .xreq_ready(xreq_ready),
		.xresp_page(xresp_page), .xresp_ok(xresp_ok),
		.xresp_valid(xresp_valid), .xresp_ready(xresp_ready),
		.w_ar_addr(w_ar_addr), .w_ar_valid(w_ar_valid), .w_ar_ready(w_ar_ready),
		.w_r_data(w_r_data), .w_r_valid(w_r_valid), .w_r_ready(w_r_ready)
	);

	phys_read_arb u_arb (
		.clk(clk), .rst(rst),
		.w_ar_addr(w_ar_addr), .w_ar_valid(w_ar_valid), .w_ar_ready(w_ar_ready),
		.w_r_data(w_r_data), .w_r_valid(w_r_valid), .w_r_ready(w_r_ready),
		.p_ar_addr(p_ar_addr), .p_ar_len(p_ar_len), .p_ar_size(p_ar_size),
		.p_ar_valid(p_ar_valid), .p_ar_ready(p_ar_ready),
		.p_r_data(p_r_data), .p_r_resp(p_r_resp), .p_r_last(p_r_last),
		.p_r_valid(p_r_valid), .p_r_ready(p_r_ready),
		.m_ar_id(m_ar_id), .m_ar_addr(m_ar_addr), .m_ar_len(m_ar_len),
		.m_ar_size(m_ar_size), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
		.m_r_id(m_r_id), .m_r_data(m_r_data), .m_r_resp(m_r_resp),
		.m_r_last(m_r_last), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready)
	);

endmodule

// ==== source/page_walker.sv ====
// page table walker
`timescale 1ns/1ps

module page_walker #(
	parameter logic [xlat_pkg::PTE_APP_HI-xlat_pkg::PTE_APP_LO:0] APP_ID = '0,
	parameter int LOG_DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        rst,

	input  logic [xlat_pkg::PAGE_W-1:0] xreq_page,
	input  logic                        xreq_valid,
	output logic                        xreq_ready,

	output logic [xlat_pkg::PAGE_W-1:0] xresp_page,
	output logic                        xresp_ok,
	output logic                        xresp_valid,
	input  logic                        xresp_ready,

	output logic [xlat_pkg::ADDR_W-1:0] w_ar_addr,
	output logic                        w_ar_valid,
	input  logic                        w_ar_ready,

	input  logic [xlat_pkg::DATA_W-1:0] w_r_data,
	input  logic                        w_r_valid,
	output logic                        w_r_ready
);
	// byte offset bits of one 64-byte line
	localparam int LINE_OFS_W = $clog2(xlat_pkg::DATA_W / 8);

	logic [xlat_pkg::PAGE_W-1:0] pf_rd_data;
	logic [xlat_pkg::ADDR_W-1:0] laf_wr_data;
	logic [xlat_pkg::ADDR_W-1:0] laf_wr_data_q;
	logic [xlat_pkg::DATA_W-1:0] lf_rd_data;
	xlat_pkg::xlat_t res_wr_data, res_rd_data;

	logic pf_full, pf_empty;
	logic laf_full, laf_empty, laf_rd;
	logic lf_full, lf_empty, lf_wr;
	logic res_full, res_empty, res_rd;
	logic req_accept, walk_done;

	logic                        hit [xlat_pkg::PTES_PER_LINE];
	logic [xlat_pkg::PAGE_W-1:0] rpn [xlat_pkg::PTES_PER_LINE];
	logic                        any_hit;
	logic [xlat_pkg::PAGE_W-1:0] rpn_merged;

	// buffer page and its entry line address together
	assign xreq_ready = !pf_full && !laf_full;
	assign req_accept = xreq_valid && xreq_ready;
	assign laf_wr_data = {{(xlat_pkg::ADDR_W - xlat_pkg::LINE_INDEX_W - LINE_OFS_W){1'b0}},
		xreq_page[xlat_pkg::LINE_INDEX_W-1:0], {LINE_OFS_W{1'b0}}};

	assign w_ar_addr = laf_wr_data_q;
	assign w_ar_valid = !laf_empty;
	assign laf_rd = w_ar_valid && w_ar_ready;

	assign w_r_ready = !lf_full;
	assign lf_wr = w_r_valid && w_r_ready;

	for (genvar g = 0; g < xlat_pkg::PTES_PER_LINE; g++) begin : g_match
		pte_match #(.APP_ID(APP_ID)) u_match (
			.pte(lf_rd_data[g*xlat_pkg::PTE_W +: xlat_pkg::PTE_W]),
			.vpn(pf_rd_data),
			.hit(hit[g]),
			.rpn(rpn[g])
		);
	end

	// at most one slot should hit, so OR is enough
	always_comb begin
		any_hit = 1'b0;
		rpn_merged = '0;
		for (int i = 0; i < xlat_pkg::PTES_PER_LINE; i++) begin
			any_hit = any_hit | hit[i];
			rpn_merged = rpn_merged | rpn[i];
		end
	end

	assign walk_done = !pf_empty && !lf_empty && !res_full;
	assign res_wr_data = '{page: rpn_merged, ok: any_hit};

	assign xresp_page = res_rd_data.page;
	assign xresp_ok = res_rd_data.ok;
	assign xresp_valid = !res_empty;
	assign res_rd = xresp_valid && xresp_ready;

	sync_fifo #(.T(logic [xlat_pkg::PAGE_W-1:0]), .LOG_DEPTH(LOG_DEPTH)) page_fifo (
		.clk(clk), .rst(rst),
		.wr_en(req_accept), .wr_data(xreq_page), .full(pf_full),
		.rd_en(walk_done), .rd_data(pf_rd_data), .empty(pf_empty)
	);

	sync_fifo #(.T(logic [xlat_pkg::ADDR_W-1:0]), .LOG_DEPTH(LOG_DEPTH)) line_addr_fifo (
		.clk(clk), .rst(rst),
		.wr_en(req_accept), .wr_data(laf_wr_data), .full(laf_full),
		.rd_en(laf_rd), .rd_data(laf_wr_data_q), .empty(laf_empty)
	);

	sync_fifo #(.T(logic [xlat_pkg::DATA_W-1:0]), .LOG_DEPTH(LOG_DEPTH)) line_fifo (
		.clk(clk), .rst(rst),
		.wr_en(lf_wr), .wr_data(w_r_data), .full(lf_full),
		.rd_en(walk_done), .rd_data(lf_rd_data), .empty(lf_empty)
	);

	sync_fifo #(.T(xlat_pkg::xlat_t), .LOG_DEPTH(LOG_DEPTH)) result_fifo (
		.clk(clk), .rst(rst),
		.wr_en(walk_done), .wr_data(res_wr_data), .full(res_full),
		.rd_en(res_rd), .rd_data(res_rd_data), .empty(res_empty)
	);

endmodule

// ==== source/phys_read_arb.sv ====
// physical read port arbiter
`timescale 1ns/1ps

module phys_read_arb (
	input  logic                        clk,
	input  logic                        rst,

	// walker side
	input  logic [xlat_pkg::ADDR_W-1:0] w_ar_addr,
	input  logic                        w_ar_valid,
	output logic                        w_ar_ready,
	output logic [xlat_pkg::DATA_W-1:0] w_r_data,
	output logic                        w_r_valid,
	input  logic                        w_r_ready,

	// read path side
	input  logic [xlat_pkg::ADDR_W-1:0] p_ar_addr,
	input  logic [xlat_pkg::LEN_W-1:0]  p_ar_len,
	input  logic [xlat_pkg::SIZE_W-1:0] p_ar_size,
	input  logic                        p_ar_valid,
	output logic                        p_ar_ready,
	output logic [xlat_pkg::DATA_W-1:0] p_r_data,
	output logic [xlat_pkg::RESP_W-1:0] p_r_resp,
	output logic                        p_r_last,
	output logic                        p_r_valid,
	input  logic                        p_r_ready,

	// physical memory side
	output logic [xlat_pkg::ID_W-1:0]   m_ar_id,
	output logic [xlat_pkg::ADDR_W-1:0] m_ar_addr,
	output logic [xlat_pkg::LEN_W-1:0]  m_ar_len,
	output logic [xlat_pkg::SIZE_W-1:0] m_ar_size,
	output logic                        m_ar_valid,
	input  logic                        m_ar_ready,
	input  logic [xlat_pkg::ID_W-1:0]   m_r_id,
	input  logic [xlat_pkg::DATA_W-1:0] m_r_data,
	input  logic [xlat_pkg::RESP_W-1:0] m_r_resp,
	input  logic                        m_r_last,
	input  logic                        m_r_valid,
	output logic                        m_r_ready
);
	// walker fetches exactly one full line
	localparam logic [xlat_pkg::SIZE_W-1:0] LINE_SIZE = 3'b110;

	logic req_tag, ret_tag;

	// walker wins, tag 0 for walker and 1 for read path
	assign req_tag = !w_ar_valid;
	assign m_ar_id = {{(xlat_pkg::ID_W-1){1'b0}}, req_tag};
	assign m_ar_addr = req_tag ? p_ar_addr : w_ar_addr;
	assign m_ar_len = req_tag ? p_ar_len : '0;
	assign m_ar_size = req_tag ? p_ar_size : LINE_SIZE;
	assign m_ar_valid = w_ar_valid || p_ar_valid;
	assign w_ar_ready = !req_tag && m_ar_ready;
	assign p_ar_ready = req_tag && m_ar_ready;

	// route beats back by the tag bit
	assign ret_tag = m_r_id[0];
	assign w_r_data = m_r_data;
	assign w_r_valid = m_r_valid && !ret_tag;
	assign p_r_data = m_r_data;
	assign p_r_resp = m_r_resp;
	assign p_r_last = m_r_last;
	assign p_r_valid = m_r_valid && ret_tag;
	assign m_r_ready = ret_tag ? p_r_ready : w_r_ready;

	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		!(w_ar_ready && p_ar_ready));

endmodule

// ==== source/pte_match.sv ====
// page table entry matcher
`timescale 1ns/1ps

module pte_match #(
	parameter logic [xlat_pkg::PTE_APP_HI-xlat_pkg::PTE_APP_LO:0] APP_ID = '0
) (
	input  logic [xlat_pkg::PTE_W-1:0]  pte,
	input  logic [xlat_pkg::PAGE_W-1:0] vpn,
	output logic                        hit,
	output logic [xlat_pkg::PAGE_W-1:0] rpn
);
	logic present, tag_ok, app_ok;

	assign present = pte[xlat_pkg::PTE_PRESENT_BIT];

	// tag is narrower than the page number, upper bits must be zero
	assign tag_ok = (vpn ==
		xlat_pkg::PAGE_W'(pte[xlat_pkg::PTE_TAG_HI:xlat_pkg::PTE_TAG_LO]));
	assign app_ok = (pte[xlat_pkg::PTE_APP_HI:xlat_pkg::PTE_APP_LO] == APP_ID);

	assign hit = present && tag_ok && app_ok;

	// zero on a miss so the walker can OR all slots
	assign rpn = hit ?
		xlat_pkg::PAGE_W'(pte[xlat_pkg::PTE_RPN_HI:xlat_pkg::PTE_RPN_LO]) : '0;

endmodule

// ==== source/read_xlat.sv ====
// translated AXI read path
`timescale 1ns/1ps

module read_xlat #(
	parameter int LOG_DEPTH = 4
) (
	input  logic                          clk,
	input  logic                          rst,

	input  logic [xlat_pkg::ID_W-1:0]     ar_id,
	input  logic [xlat_pkg::ADDR_W-1:0]   ar_addr,
	input  logic [xlat_pkg::LEN_W-1:0]    ar_len,
	input  logic [xlat_pkg::SIZE_W-1:0]   ar_size,
	input  logic                          ar_valid,
	output logic                          ar_ready,

	output logic [xlat_pkg::ID_W-1:0]     r_id,
	output logic [xlat_pkg::DATA_W-1:0]   r_data,
	output logic [xlat_pkg::RESP_W-1:0]   r_resp,
	output logic                          r_last,
	output logic                          r_valid,
	input  logic                          r_ready,

	output logic [xlat_pkg::PAGE_W-1:0]   xreq_page,
	output logic                          xreq_valid,
	input  logic                          xreq_ready,

	input  logic [xlat_pkg::PAGE_W-1:0]   xresp_page,
	input  logic                          xresp_ok,
	input  logic                          xresp_valid,
	output logic                          xresp_ready,

	output logic [xlat_pkg::ADDR_W-1:0]   p_ar_addr,
	output logic [xlat_pkg::LEN_W-1:0]    p_ar_len,
	output logic [xlat_pkg::SIZE_W-1:0]   p_ar_size,
	output logic                          p_ar_valid,
	input  logic                          p_ar_ready,

	input  logic [xlat_pkg::DATA_W-1:0]   p_r_data,
	input  logic [xlat_pkg::RESP_W-1:0]   p_r_resp,
	input  logic                          p_r_last,
	input  logic                          p_r_valid,
	output logic                          p_r_ready
);
	xlat_pkg::ar_meta_t  mf_wr_data, mf_rd_data;
	xlat_pkg::xlat_t     xf_wr_data, xf_rd_data;
	xlat_pkg::ret_meta_t rmf_wr_data, rmf_rd_data;
	xlat_pkg::rbeat_t    rrf_wr_data, rrf_rd_data;
	logic [xlat_pkg::PAGE_W-1:0] pf_wr_data;
	logic [xlat_pkg::PAGE_W-1:0] pf_rd_data;

	logic mf_full, mf_empty, mf_rd;
	logic pf_full, pf_empty, pf_rd;
	logic xf_full, xf_empty, xf_wr, xf_rd;
	logic rmf_full, rmf_empty, rmf_rd;
	logic rrf_full, rrf_empty, rrf_wr, rrf_rd;
	logic ar_accept, paired, pair_pop, r_fire;

	// accept and split the request
	assign ar_ready = !mf_full && !pf_full;
	assign ar_accept = ar_valid && ar_ready;
	assign mf_wr_data = '{id: ar_id, len: ar_len, size: ar_size,
		offset: ar_addr[xlat_pkg::OFFSET_W-1:0]};
	assign pf_wr_data = ar_addr[xlat_pkg::ADDR_W-1:xlat_pkg::OFFSET_W];

	assign xreq_page = pf_rd_data;
	assign xreq_valid = !pf_empty;
	assign pf_rd = xreq_valid && xreq_ready;

	// buffer translation results
	assign xresp_ready = !xf_full;
	assign xf_wr = xresp_valid && xresp_ready;
	assign xf_wr_data = '{page: xresp_page, ok: xresp_ok};

	// pair metadata with translation, forward only when mapped
	assign paired = !mf_empty && !xf_empty && !rmf_full;
	assign p_ar_valid = paired && xf_rd_data.ok;
	assign p_ar_addr = {xf_rd_data.page, mf_rd_data.offset};
	assign p_ar_len = mf_rd_data.len;
	assign p_ar_size = mf_rd_data.size;
	assign pair_pop = paired && (xf_rd_data.ok ? p_ar_ready : 1'b1);
	assign mf_rd = pair_pop;
	assign xf_rd = pair_pop;
	assign rmf_wr_data = '{id: mf_rd_data.id, fwd: xf_rd_data.ok};

	// returning physical beats
	assign p_r_ready = !rrf_full;
	assign rrf_wr = p_r_valid && p_r_ready;
	assign rrf_wr_data = '{data: p_r_data, resp: p_r_resp, last: p_r_last};

	// faulted entries produce a single error beat
	assign r_valid = !rmf_empty && (rmf_rd_data.fwd ? !rrf_empty : 1'b1);
	assign r_fire = r_valid && r_ready;
	assign rrf_rd = r_fire && rmf_rd_data.fwd;
	assign rmf_rd = r_fire && (rmf_rd_data.fwd ? rrf_rd_data.last : 1'b1);

	assign r_id = rmf_rd_data.id;
	assign r_data = rmf_rd_data.fwd ? rrf_rd_data.data : '0;
	assign r_resp = rmf_rd_data.fwd ? rrf_rd_data.resp : xlat_pkg::RESP_SLVERR;
	assign r_last = rmf_rd_data.fwd ? rrf_rd_data.last : 1'b1;

	sync_fifo #(.T(xlat_pkg::ar_meta_t), .LOG_DEPTH(LOG_DEPTH)) meta_fifo (
		.clk(clk), .rst(rst),
		.wr_en(ar_accept), .wr_data(mf_wr_data), .full(mf_full),
		.rd_en(mf_rd), .rd_data(mf_rd_data), .empty(mf_empty)
	);

	sync_fifo #(.T(logic [xlat_pkg::PAGE_W-1:0]), .LOG_DEPTH(LOG_DEPTH)) page_fifo (
		.clk(clk), .rst(rst),
		.wr_en(ar_accept), .wr_data(pf_wr_data), .full(pf_full),
		.rd_en(pf_rd), .rd_data(pf_rd_data), .empty(pf_empty)
	);

	sync_fifo #(.T(xlat_pkg::xlat_t), .LOG_DEPTH(LOG_DEPTH)) xlat_fifo (
		.clk(clk), .rst(rst),
		.wr_en(xf_wr), .wr_data(xf_wr_data), .full(xf_full),
		.rd_en(xf_rd), .rd_data(xf_rd_data), .empty(xf_empty)
	);

	sync_fifo #(.T(xlat_pkg::ret_meta_t), .LOG_DEPTH(LOG_DEPTH)) ret_meta_fifo (
		.clk(clk), .rst(rst),
		.wr_en(pair_pop), .wr_data(rmf_wr_data), .full(rmf_full),
		.rd_en(rmf_rd), .rd_data(rmf_rd_data), .empty(rmf_empty)
	);

	sync_fifo #(.T(xlat_pkg::rbeat_t), .LOG_DEPTH(LOG_DEPTH)) ret_fifo (
		.clk(clk), .rst(rst),
		.wr_en(rrf_wr), .wr_data(rrf_wr_data), .full(rrf_full),
		.rd_en(rrf_rd), .rd_data(rrf_rd_data), .empty(rrf_empty)
	);

	a_rvalid_has_meta: assert property (@(posedge clk) disable iff (rst)
		$rose(r_valid) |-> !rmf_empty);

endmodule

// ==== source/sync_fifo.sv ====
// show-ahead synchronous FIFO
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T = logic,
	parameter int LOG_DEPTH = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic wr_en,
	input  T     wr_data,
	output logic full,
	input  logic rd_en,
	output T     rd_data,
	output logic empty
);
	localparam int DEPTH = 1 << LOG_DEPTH;

	T mem [DEPTH];

	// extra msb tells full from empty
	logic [LOG_DEPTH:0] wr_ptr;
	logic [LOG_DEPTH:0] rd_ptr;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[LOG_DEPTH-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	assign rd_data = mem[rd_ptr[LOG_DEPTH-1:0]];
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH]) &&
		(wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]);

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr_en && full));
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd_en && empty));

endmodule

// ==== source/xlat_pkg.sv ====
// address translation definitions
package xlat_pkg;

	localparam int ADDR_W = 64;
	localparam int OFFSET_W = 12;
	localparam int PAGE_W = ADDR_W - OFFSET_W;
	localparam int ID_W = 16;
	localparam int LEN_W = 8;
	localparam int SIZE_W = 3;
	localparam int RESP_W = 2;
	localparam int DATA_W = 512;
	localparam int PTE_W = 64;
	localparam int PTES_PER_LINE = DATA_W / PTE_W;

	localparam logic [RESP_W-1:0] RESP_OKAY = 2'd0;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

	// page table entry layout
	localparam int PTE_PRESENT_BIT = 0;
	localparam int PTE_RPN_LO = 2;
	localparam int PTE_RPN_HI = 25;
	localparam int PTE_TAG_LO = 26;
	localparam int PTE_TAG_HI = 61;
	localparam int PTE_APP_LO = 62;
	localparam int PTE_APP_HI = 63;

	// low page bits that pick the entry line
	localparam int LINE_INDEX_W = 23;

	typedef struct packed {
		logic [ID_W-1:0]     id;
		logic [LEN_W-1:0]    len;
		logic [SIZE_W-1:0]   size;
		logic [OFFSET_W-1:0] offset;
	} ar_meta_t;

	typedef struct packed {
		logic [PAGE_W-1:0] page;
		logic              ok;
	} xlat_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic            fwd;
	} ret_meta_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		logic              last;
	} rbeat_t;

endpackage

// ==== tb/phys_mem_model.sv ====
// physical memory model
`timescale 1ns/1ps

module phys_mem_model (
	input  logic         clk,
	input  logic         rst,
	input  logic [15:0]  ar_id,
	input  logic [63:0]  ar_addr,
	input  logic [7:0]   ar_len,
	input  logic         ar_valid,
	output logic         ar_ready,
	output logic [15:0]  r_id,
	output logic [511:0] r_data,
	output logic [1:0]   r_resp,
	output logic         r_last,
	output logic         r_valid,
	input  logic         r_ready
);
	// entry words by line index, data reads by physical page
	logic [63:0] pte_by_line [logic [22:0]];
	int reads_of_page [logic [51:0]];
	// data reads of any page
	int data_read_total = 0;

	// accepted requests in arrival order
	logic [15:0] q_id [$];
	logic [63:0] q_addr [$];
	logic [7:0] q_len [$];
	int beat;

	task automatic set_entry(input logic [51:0] page, input logic [63:0] pte);
		pte_by_line[page[22:0]] = pte;
	endtask

	function automatic int data_reads(input logic [51:0] ppage);
		if (reads_of_page.exists(ppage))
			return reads_of_page[ppage];
		return 0;
	endfunction

	// one entry sits in slot page mod 8 of its line
	function automatic logic [511:0] line_data(input logic [63:0] addr);
		logic [511:0] words;
		int slot;
		words = '0;
		slot = int'(addr[8:6]);
		if (pte_by_line.exists(addr[28:6]))
			words[slot*64 +: 64] = pte_by_line[addr[28:6]];
		return words;
	endfunction

	initial begin
		ar_ready = 1'b0;
		r_id = '0;
		r_data = '0;
		r_resp = '0;
		r_last = 1'b0;
		r_valid = 1'b0;
		beat = 0;
		forever begin
			@(posedge clk);
			if (rst) begin
				q_id.delete();
				q_addr.delete();
				q_len.delete();
				beat = 0;
			end else begin
				if (r_valid && r_ready) begin
					if (beat == int'(q_len[0])) begin
						void'(q_id.pop_front());
						void'(q_addr.pop_front());
						void'(q_len.pop_front());
						beat = 0;
					end else begin
						beat++;
					end
				end
				if (ar_valid && ar_ready) begin
					q_id.push_back(ar_id);
					q_addr.push_back(ar_addr);
					q_len.push_back(ar_len);
					// tag bit 1 marks a data read
					if (ar_id[0]) begin
						reads_of_page[ar_addr[63:12]] = data_reads(ar_addr[63:12]) + 1;
						data_read_total++;
					end
				end
			end
			#1;
			ar_ready = !rst;
			if (q_id.size() != 0) begin
				r_valid = 1'b1;
				r_id = q_id[0];
				r_resp = 2'd0;
				r_last = (beat == int'(q_len[0]));
				if (q_id[0][0])
					r_data = {8{q_addr[0] + 64'(beat)}};
				else
					r_data = line_data(q_addr[0]);
			end else begin
				r_valid = 1'b0;
			end
		end
	end

endmodule

// ==== tb/tb_axi_read_xlat.sv ====
// AXI read translation testbench
`timescale 1ns/1ps

module tb_axi_read_xlat;
	localparam logic [1:0] APP_ID = 2'd1;
	localparam int ROWS = 8;
	localparam int PASSES = 2;
	localparam int TIMEOUT = 300 * ROWS * PASSES + 100;
	// requests use 32-byte beats, walker lines use 64-byte beats
	localparam logic [2:0] REQ_SIZE = 3'd5;
	localparam logic [2:0] LINE_SIZE = 3'd6;

	// row kinds
	localparam int MAPPED = 0;
	localparam int NO_ENTRY = 1;
	localparam int WRONG_APP = 2;
	localparam int NOT_PRESENT = 3;

	// one row per request: id, virtual address, length, kind, real page
	localparam logic [15:0] T_ID [ROWS] = '{16'h0a01, 16'h0a02, 16'h0a03, 16'h0b04,
		16'h0b05, 16'h0c06, 16'h0c07, 16'h0c08};
	localparam logic [63:0] T_ADDR [ROWS] = '{64'h0000_0000_0012_3040,
		64'h0000_0000_0045_6100, 64'h0000_0001_2345_6ff0, 64'h0000_0000_0000_7008,
		64'h0000_0000_0009_9000, 64'h0000_000f_0000_1200, 64'h0000_0000_0003_3010,
		64'h0000_0000_0021_0000};
	localparam logic [7:0] T_LEN [ROWS] = '{8'd3, 8'd0, 8'd1, 8'd2, 8'd0, 8'd7, 8'd4, 8'd0};
	localparam int T_KIND [ROWS] = '{MAPPED, NO_ENTRY, MAPPED, WRONG_APP, NOT_PRESENT,
		MAPPED, MAPPED, NO_ENTRY};
	localparam logic [23:0] T_RPN [ROWS] = '{24'h000456, 24'h000777, 24'h00abcd,
		24'h000888, 24'h000999, 24'h123457, 24'h000321, 24'h000aaa};

	logic clk = 1'b0;
	logic rst;
	logic [15:0] ar_id;
	logic [63:0] ar_addr;
	logic [7:0] ar_len;
	logic [2:0] ar_size;
	logic ar_valid;
	logic ar_ready;
	logic [15:0] r_id;
	logic [511:0] r_data;
	logic [1:0] r_resp;
	logic r_last;
	logic r_valid;
	logic r_ready = 1'b0;

	logic [15:0] m_ar_id, m_r_id;
	logic [63:0] m_ar_addr;
	logic [7:0] m_ar_len;
	logic [2:0] m_ar_size;
	logic [511:0] m_r_data;
	logic [1:0] m_r_resp;
	logic m_ar_valid, m_ar_ready, m_r_last, m_r_valid, m_r_ready;

	int errors = 0;
	int beats = 0;
	int cycles = 0;
	bit random_ready = 1'b0;
	integer seed = 44;

	// expected beats in return order
	logic [15:0] exp_id [$];
	logic [511:0] exp_data [$];
	logic [1:0] exp_resp [$];
	bit exp_last [$];
	bit exp_fault [$];

	axi_read_xlat #(.APP_ID(APP_ID), .LOG_DEPTH(4)) dut0 (
		.clk(clk), .rst(rst),
		.ar_id(ar_id), .ar_addr(ar_addr), .ar_len(ar_len), .ar_size(ar_size),
		.ar_valid(ar_valid), .ar_ready(ar_ready),
		.r_id(r_id), .r_data(r_data), .r_resp(r_resp), .r_last(r_last),
		.r_valid(r_valid), .r_ready(r_ready),
		.m_ar_id(m_ar_id), .m_ar_addr(m_ar_addr), .m_ar_len(m_ar_len),
		.m_ar_size(m_ar_size), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
		.m_r_id(m_r_id), .m_r_data(m_r_data), .m_r_resp(m_r_resp),
		.m_r_last(m_r_last), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready)
	);

	phys_mem_model mem0 (
		.clk(clk), .rst(rst),
		.ar_id(m_ar_id), .ar_addr(m_ar_addr), .ar_len(m_ar_len),
		.ar_valid(m_ar_valid), .ar_ready(m_ar_ready),
		.r_id(m_r_id), .r_data(m_r_data), .r_resp(m_r_resp), .r_last(m_r_last),
		.r_valid(m_r_valid), .r_ready(m_r_ready)
	);

	always #10 clk = ~clk;

	task automatic report_mismatch(input string msg);
		errors++;
		$display("mismatch %0t: %s", $time, msg);
	endtask

	// entry word built from the row: present, real page, tag, app id
	function automatic logic [63:0] make_pte(input int r);
		logic [63:0] pte;
		pte = '0;
		pte[0] = (T_KIND[r] != NOT_PRESENT);
		pte[25:2] = T_RPN[r];
		pte[61:26] = T_ADDR[r][47:12];
		pte[63:62] = (T_KIND[r] == WRONG_APP) ? 2'd2 : APP_ID;
		return pte;
	endfunction

	task automatic expect_row(input int r);
		logic [63:0] pa;
		pa = {28'd0, T_RPN[r], T_ADDR[r][11:0]};
		if (T_KIND[r] == MAPPED) begin
			for (int k = 0; k <= int'(T_LEN[r]); k++) begin
				exp_id.push_back(T_ID[r]);
				exp_data.push_back({8{pa + 64'(k)}});
				exp_resp.push_back(2'd0);
				exp_last.push_back(k == int'(T_LEN[r]));
				exp_fault.push_back(1'b0);
			end
		end else begin
			exp_id.push_back(T_ID[r]);
			exp_data.push_back('0);
			exp_resp.push_back(2'd2);
			exp_last.push_back(1'b1);
			exp_fault.push_back(1'b1);
		end
	endtask

	// called 1 ns after an edge, returns 1 ns after the handshake edge
	task automatic send_request(input int r);
		ar_id = T_ID[r];
		ar_addr = T_ADDR[r];
		ar_len = T_LEN[r];
		ar_size = REQ_SIZE;
		ar_valid = 1'b1;
		@(posedge clk);
		while (!ar_ready)
			@(posedge clk);
		#1;
		ar_valid = 1'b0;
	endtask

	task automatic check_idle(input string phase);
		assert (r_valid === 1'b0 && m_ar_valid === 1'b0)
			else report_mismatch($sformatf("valid output high %s", phase));
	endtask

	always @(posedge clk) begin
		#1;
		if (rst)
			r_ready = 1'b0;
		else if (random_ready)
			r_ready = ($random(seed) % 3) != 0;
		else
			r_ready = 1'b1;
	end

	// walker reads one line, data reads keep the requested size
	always @(posedge clk) begin
		if (!rst && m_ar_valid && m_ar_ready) begin
			assert (m_ar_id[0] ? (m_ar_size == REQ_SIZE)
					: (m_ar_size == LINE_SIZE && m_ar_len == 8'd0))
				else report_mismatch($sformatf("physical read tag %0d len %0d size %0d",
					m_ar_id[0], m_ar_len, m_ar_size));
		end
	end

	// compare every returned beat against the head of the expected queue
	always @(posedge clk) begin
		if (!rst && r_valid && r_ready) begin
			beats++;
			assert (exp_id.size() != 0) else begin
				errors++;
				$display("%0t: beat with id %h arrived when none was expected", $time, r_id);
			end
			if (exp_id.size() != 0) begin
				assert ({r_id, r_resp, r_last} == {exp_id[0], exp_resp[0], exp_last[0]})
					else report_mismatch($sformatf("id %h resp %0d last %0d, expected %h %0d %0d",
						r_id, r_resp, r_last, exp_id[0], exp_resp[0], exp_last[0]));
				assert (exp_fault[0] || r_data == exp_data[0])
					else report_mismatch($sformatf("id %h data %h, expected %h",
						r_id, r_data[63:0], exp_data[0][63:0]));
				void'(exp_id.pop_front());
				void'(exp_data.pop_front());
				void'(exp_resp.pop_front());
				void'(exp_last.pop_front());
				void'(exp_fault.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout: run not done within %0d cycles, %0d errors", TIMEOUT, errors);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		int reads;
		int mapped;
		rst = 1'b1;
		ar_id = '0;
		ar_addr = '0;
		ar_len = '0;
		ar_size = '0;
		ar_valid = 1'b0;
		for (int r = 0; r < ROWS; r++) begin
			if (T_KIND[r] != NO_ENTRY)
				mem0.set_entry(T_ADDR[r][63:12], make_pte(r));
		end
		@(posedge clk);
		repeat (15) begin
			@(posedge clk);
			check_idle("during reset");
		end
		#1;
		rst = 1'b0;
		repeat (2) begin
			@(posedge clk);
			check_idle("after reset");
		end
		#1;
		// first pass with rready high, second with random stalls
		for (int p = 0; p < PASSES; p++) begin
			random_ready = (p == 1);
			for (int r = 0; r < ROWS; r++)
				expect_row(r);
			for (int r = 0; r < ROWS; r++)
				send_request(r);
			while (exp_id.size() != 0)
				@(posedge clk);
			#1;
		end
		// stray beats would show up here
		repeat (20) @(posedge clk);
		mapped = 0;
		for (int r = 0; r < ROWS; r++) begin
			if (T_KIND[r] == MAPPED)
				mapped++;
			// a refused entry still names its real page
			if (T_KIND[r] != NO_ENTRY) begin
				reads = mem0.data_reads({28'd0, T_RPN[r]});
				assert (reads == ((T_KIND[r] == MAPPED) ? PASSES : 0))
					else report_mismatch($sformatf("row %0d physical page %h read %0d times",
						r, T_RPN[r], reads));
			end
		end
		assert (mem0.data_read_total == mapped * PASSES)
			else report_mismatch($sformatf("%0d physical data reads, expected %0d",
				mem0.data_read_total, mapped * PASSES));
		$display("checked %0d beats, %0d errors", beats, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
